// File: build.f
xcom_link_pkg.sv
xcom_ctrl_pkg.sv
xcom_cmd.sv
xcom_tx.sv
xcom_rx.sv
xcom_exec.sv
xcom_top.sv
tb_xcom.sv

// File: run_sim.sh
#!/bin/bash
# compile with Verilator, run, and look for the pass line in the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_xcom -f build.f \
  -o tb_xcom_sim > build.log 2>&1 \
  && ./obj_dir/tb_xcom_sim > sim.log 2>&1 \
  || { cat build.log sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -q "^TEST OK$" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

// File: tb_xcom.sv
// loopback testbench with file-driven commands and serial format, tick, executor and busy checks
`timescale 1ns/1ns
`default_nettype none

module tb_xcom
  import xcom_link_pkg::*;
  import xcom_ctrl_pkg::*;
();

  logic              clk = 1'b0;
  logic              rstn;
  logic              core_en;
  xcom_cmd_t         core_cmd;
  logic [TICK_W-1:0] cfg_tick;
  logic              sync = 1'b0;
  logic              sync_q;
  logic              core_ready;
  logic              xcom_clk;
  logic              xcom_data;
  logic [ID_W-1:0]   xcom_id;
  xcom_ctrl_t        ctrl;

  // four stimulus words per command hold header, data, tick and bit count
  logic [31:0] stim [0:255];
  int          mismatches = 0;
  int          failures = 0;
  int          limit_cycles = 0;
  logic        limit_ready = 1'b0;

  // serial monitor state
  logic        clk_prev = 1'b0;
  int          edge_cnt = 0;
  int          gap = 0;
  int          cur_hp = 2;
  logic        seen_bits[$];
  // pulse count per flag from proc_start (0) to qp_valid (6)
  int          pulse_cnt [0:6];
  logic [31:0] last_value;

  always #20 clk = ~clk;

  // serial pair looped straight back into the receiver
  xcom_top xcom_top_i (
    .i_ps_clk     (clk),
    .i_ps_rstn    (rstn),
    .i_core_en    (core_en),
    .i_core_cmd   (core_cmd),
    .i_cfg_tick   (cfg_tick),
    .i_sync       (sync),
    .i_xcom_clk   (xcom_clk),
    .i_xcom_data  (xcom_data),
    .o_core_ready (core_ready),
    .o_xcom_clk   (xcom_clk),
    .o_xcom_data  (xcom_data),
    .o_xcom_id    (xcom_id),
    .o_ctrl       (ctrl)
  );

  task automatic report_mismatch(input string msg);
    $display("Mismatch at %0t ns: %s", $time, msg);
    mismatches++;
  endtask

  task automatic report_failure(input string msg);
    $display("Error at %0t ns: %s", $time, msg);
    failures++;
  endtask

  //////////////////////////////////////////////////
  // random sync pulses on about one cycle in eight
  //////////////////////////////////////////////////
  always @(negedge clk) begin
    if (rstn) begin
      sync <= (($urandom % 32'd8) == 32'd0);
    end else begin
      sync <= 1'b0;
    end
  end

  // sync as the DUT saw it at the last rising edge
  always @(posedge clk) begin
    sync_q <= sync;
  end

  //////////////////////////////////////////////////
  // monitor sampling on the falling edge
  //////////////////////////////////////////////////
  always @(negedge clk) begin
    if (rstn) begin
      gap = gap + 1;
      if (xcom_clk != clk_prev) begin
        // every half period is 2 * (tick + 1) cycles
        if (edge_cnt > 0 && gap != cur_hp) begin
          report_mismatch($sformatf("half period %0d cycles, expected %0d", gap, cur_hp));
        end
        edge_cnt = edge_cnt + 1;
        gap = 0;
        if (xcom_clk) begin
          seen_bits.push_back(xcom_data);
        end
      end
      clk_prev = xcom_clk;
      if (ctrl.proc_start) pulse_cnt[0]++;
      if (ctrl.proc_stop) pulse_cnt[1]++;
      if (ctrl.core_start) pulse_cnt[2]++;
      if (ctrl.core_stop) pulse_cnt[3]++;
      if (ctrl.time_rst) pulse_cnt[4]++;
      if (ctrl.time_update) pulse_cnt[5]++;
      if (ctrl.qp_valid) pulse_cnt[6]++;
      if (ctrl.qp_valid || ctrl.time_update) last_value = ctrl.value;
      if (ctrl.time_rst && !sync_q) begin
        report_mismatch("time_rst pulsed without a sync pulse in the cycle before");
      end
    end
  end

  task automatic wait_ready(input int limit);
    int cycles;
    cycles = 0;
    while (!core_ready && cycles < limit) begin
      @(negedge clk);
      cycles++;
    end
    if (!core_ready) report_failure("timed out waiting for o_core_ready");
  endtask

  task automatic run_command(input logic [7:0] hdr, input logic [31:0] data,
                             input logic [2:0] tick, input int exp_count);
    logic [1:0]  kind;
    int          n;
    int          rule_count;
    int          exp_idx;
    int          cycles;
    int          limit;
    logic [39:0] frame;
    logic [63:0] mask;
    logic [31:0] exp_value;
    kind = {hdr[7], hdr[4]};
    n = (hdr[6:5] == 2'd0) ? 0 : (hdr[6:5] == 2'd1) ? 8 : (hdr[6:5] == 2'd2) ? 16 : 32;
    rule_count = (kind == 2'b11) ? 0 : 8 + n;
    if (rule_count != exp_count) begin
      report_mismatch($sformatf("header %h gives %0d bits, file says %0d",
                                hdr, rule_count, exp_count));
    end
    limit = rule_count * 4 * (int'(tick) + 1) + 20;
    wait_ready(limit);
    seen_bits.delete();
    edge_cnt = 0;
    cur_hp = 2 * (int'(tick) + 1);
    for (int k = 0; k < 7; k++) pulse_cnt[k] = 0;
    // strobe on the falling edge
    core_en = 1'b1;
    core_cmd = {hdr, data};
    cfg_tick = tick;
    @(negedge clk);
    core_en = 1'b0;
    if (kind == 2'b11) begin
      // set id acts locally and the line stays idle
      if (xcom_id != hdr[3:0]) begin
        report_mismatch($sformatf("o_xcom_id %h, expected %h", xcom_id, hdr[3:0]));
      end
      repeat (8) @(negedge clk);
      if (edge_cnt != 0) report_mismatch("serial clock moved on a set id command");
      return;
    end
    if (core_ready) report_mismatch("o_core_ready still high one cycle after the strobe");
    // strobe while busy must be dropped
    repeat (3) @(negedge clk);
    if (core_ready) report_failure("ready came back before the busy strobe could be issued");
    core_en = 1'b1;
    core_cmd = {8'h60, 32'h5a5a0ff0};
    @(negedge clk);
    core_en = 1'b0;
    wait_ready(limit);
    exp_idx = (kind == 2'b00) ? 6 : (kind == 2'b01) ? 5 : int'(hdr[3:0]) - 1;
    // time reset also waits for the next sync pulse
    limit = (exp_idx == 4) ? 400 : 40;
    cycles = 0;
    while (pulse_cnt[exp_idx] == 0 && cycles < limit) begin
      @(negedge clk);
      cycles++;
    end
    if (pulse_cnt[exp_idx] == 0) report_failure($sformatf("no pulse for header %h", hdr));
    repeat (10) @(negedge clk);
    // header then the low n data bits with msb first
    if (seen_bits.size() != exp_count) begin
      report_mismatch($sformatf("%0d serial bits, expected %0d", seen_bits.size(), exp_count));
    end
    frame = {hdr, data << (32 - n)};
    for (int i = 0; i < seen_bits.size() && i < 40; i++) begin
      if (seen_bits[i] != frame[39 - i]) begin
        report_mismatch($sformatf("serial bit %0d of header %h is %b", i, hdr, seen_bits[i]));
      end
    end
    for (int k = 0; k < 7; k++) begin
      if (pulse_cnt[k] != ((k == exp_idx) ? 1 : 0)) begin
        report_mismatch($sformatf("output %0d pulsed %0d times for header %h",
                                  k, pulse_cnt[k], hdr));
      end
    end
    if (exp_idx >= 5) begin
      mask = (64'd1 << n) - 64'd1;
      exp_value = data & mask[31:0];
      if (last_value != exp_value) begin
        report_mismatch($sformatf("value %h, expected %h", last_value, exp_value));
      end
    end
  endtask

  //////////////////////////////////////////////////
  // watchdog
  //////////////////////////////////////////////////
  initial begin
    wait (limit_ready);
    repeat (limit_cycles) @(posedge clk);
    $display("watchdog expired after %0d cycles, the run did not finish", limit_cycles);
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    int seed_ret;
    int ncmd;
    seed_ret = $urandom(32'h9a51947f);
    rstn = 1'b0;
    core_en = 1'b0;
    core_cmd = '0;
    cfg_tick = '0;
    for (int k = 0; k < 7; k++) pulse_cnt[k] = 0;
    for (int a = 0; a < 256; a++) stim[a] = 32'hffff_ffff;
    $readmemh("xcom_test_input.txt", stim);
    ncmd = 0;
    while (ncmd < 64 && stim[4 * ncmd] != 32'hffff_ffff) begin
      limit_cycles += int'(stim[4 * ncmd + 3]) * 4 * (int'(stim[4 * ncmd + 2]) + 1) + 20;
      ncmd++;
    end
    // margin for reset, busy strobes and sync waits
    limit_cycles += 1000 + 400 * ncmd;
    limit_ready = 1'b1;
    repeat (3) @(negedge clk);
    rstn = 1'b1;
    @(negedge clk);
    if (!core_ready || xcom_clk || xcom_data || xcom_id != '0) begin
      report_mismatch("outputs not at their reset values");
    end
    if (ctrl[DATA_W +: 7] != '0) report_mismatch("a pulse is high after reset");
    for (int c = 0; c < ncmd; c++) begin
      run_command(stim[4 * c][7:0], stim[4 * c + 1], stim[4 * c + 2][2:0],
                  int'(stim[4 * c + 3]));
    end
    $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: xcom_cmd.sv
// command intake: board id register, local/network split, launch and ready
`timescale 1ns/1ns
`default_nettype none

module xcom_cmd
  import xcom_link_pkg::*;
  import xcom_ctrl_pkg::*;
(
  input  wire logic            i_ps_clk,
  input  wire logic            i_ps_rstn,
  input  wire logic            i_core_en,
  input  wire xcom_cmd_t       i_core_cmd,
  input  wire logic            i_tx_busy,
  output logic                 o_core_ready,
  output logic                 o_launch,
  output xcom_cmd_t            o_launch_cmd,
  output logic [ID_W-1:0]      o_xcom_id
);

  logic       pending;
  logic       accept;
  logic       is_local;
  xcom_kind_e kind;

  //////////////////////////////////////////////////
  // decode
  //////////////////////////////////////////////////
  assign kind     = xcom_kind_e'(hdr_kind(i_core_cmd.hdr));
  assign is_local = (kind == KIND_SET_ID);
  // strobes while not ready are dropped here
  assign accept   = i_core_en && o_core_ready;

  // pending covers the gap between launch and busy rising
  assign o_core_ready = !pending && !i_tx_busy;

  //////////////////////////////////////////////////
  // control
  //////////////////////////////////////////////////
  always_ff @(posedge i_ps_clk) begin
    if (!i_ps_rstn) begin
      pending   <= 1'b0;
      o_launch  <= 1'b0;
      o_xcom_id <= '0;
    end else begin
      o_launch <= 1'b0;
      if (accept && is_local) begin
        // set id acts right here, the line stays idle
        o_xcom_id <= i_core_cmd.hdr.addr.board_id;
      end else if (accept) begin
        o_launch <= 1'b1;
        pending  <= 1'b1;
      end else if (i_tx_busy) begin
        // transmitter took it, busy now holds ready low
        pending <= 1'b0;
      end
    end
  end

  // launch payload
  always_ff @(posedge i_ps_clk) begin
    if (accept && !is_local) begin
      o_launch_cmd <= i_core_cmd;
    end
  end

endmodule

`default_nettype wire

// File: xcom_ctrl_pkg.sv
// command kinds, control codes and the executor output bundle
`default_nettype none

package xcom_ctrl_pkg;

  import xcom_link_pkg::*;

  //////////////////////////////////////////////////
  // command kind, header bits {7,4}
  //////////////////////////////////////////////////
  typedef enum logic [1:0] {
    // payload goes to the user data outputs
    KIND_QP_DATA = 2'b00,
    // payload loads the time counter
    KIND_TIME    = 2'b01,
    // low nibble is a control code
    KIND_CTRL    = 2'b10,
    // low nibble is the new board id, never sent
    KIND_SET_ID  = 2'b11
  } xcom_kind_e;

  //////////////////////////////////////////////////
  // control codes, low nibble of control frames
  //////////////////////////////////////////////////
  typedef enum logic [CODE_W-1:0] {
    CTRL_PROC_START = 4'h1,
    CTRL_PROC_STOP  = 4'h2,
    CTRL_CORE_START = 4'h3,
    CTRL_CORE_STOP  = 4'h4,
    CTRL_TIME_RST   = 4'h5
  } xcom_ctrl_code_e;

  // executor outputs, every flag is a one-cycle pulse
  typedef struct packed {
    logic              proc_start;
    logic              proc_stop;
    logic              core_start;
    logic              core_stop;
    logic              time_rst;
    logic              time_update;
    logic              qp_valid;
    // shared by time update and qp data
    logic [DATA_W-1:0] value;
  } xcom_ctrl_t;

endpackage

`default_nettype wire

// File: xcom_exec.sv
// frame executor: control pulses, data outputs and sync-aligned time reset
`timescale 1ns/1ns
`default_nettype none

module xcom_exec
  import xcom_link_pkg::*;
  import xcom_ctrl_pkg::*;
(
  input  wire logic       i_ps_clk,
  input  wire logic       i_ps_rstn,
  input  wire logic       i_frame_valid,
  input  wire xcom_cmd_t  i_frame,
  input  wire logic       i_sync,
  output xcom_ctrl_t      o_ctrl
);

  xcom_kind_e        kind;
  xcom_ctrl_code_e   code;
  logic              is_ctrl;
  logic              rst_armed;
  logic              proc_start;
  logic              proc_stop;
  logic              core_start;
  logic              core_stop;
  logic              time_rst;
  logic              time_update;
  logic              qp_valid;
  logic [DATA_W-1:0] value_q;

  //////////////////////////////////////////////////
  // decode
  //////////////////////////////////////////////////
  assign kind    = xcom_kind_e'(hdr_kind(i_frame.hdr));
  // control view of the same header word
  assign code    = xcom_ctrl_code_e'(i_frame.hdr.ctrl.code);
  assign is_ctrl = i_frame_valid && (kind == KIND_CTRL);

  //////////////////////////////////////////////////
  // pulses
  //////////////////////////////////////////////////
  always_ff @(posedge i_ps_clk) begin
    if (!i_ps_rstn) begin
      proc_start  <= 1'b0;
      proc_stop   <= 1'b0;
      core_start  <= 1'b0;
      core_stop   <= 1'b0;
      time_rst    <= 1'b0;
      time_update <= 1'b0;
      qp_valid    <= 1'b0;
      rst_armed   <= 1'b0;
    end else begin
      proc_start  <= is_ctrl && (code == CTRL_PROC_START);
      proc_stop   <= is_ctrl && (code == CTRL_PROC_STOP);
      core_start  <= is_ctrl && (code == CTRL_CORE_START);
      core_stop   <= is_ctrl && (code == CTRL_CORE_STOP);
      time_update <= i_frame_valid && (kind == KIND_TIME);
      qp_valid    <= i_frame_valid && (kind == KIND_QP_DATA);
      // time reset waits for the next sync pulse
      time_rst    <= rst_armed && i_sync;
      if (is_ctrl && (code == CTRL_TIME_RST)) begin
        rst_armed <= 1'b1;
      end else if (i_sync) begin
        rst_armed <= 1'b0;
      end
    end
  end

  // value shared by time update and qp data
  always_ff @(posedge i_ps_clk) begin
    if (i_frame_valid && (kind == KIND_TIME || kind == KIND_QP_DATA)) begin
      value_q <= i_frame.data;
    end
  end

  assign o_ctrl = '{
    proc_start:  proc_start,
    proc_stop:   proc_stop,
    core_start:  core_start,
    core_stop:   core_stop,
    time_rst:    time_rst,
    time_update: time_update,
    qp_valid:    qp_valid,
    value:       value_q
  };

endmodule

`default_nettype wire

// File: xcom_link_pkg.sv
// serial link wire format with widths, length codes, header union, frame word and timing helpers
`default_nettype none

package xcom_link_pkg;

  //////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////
  localparam int DATA_W  = 32;
  localparam int HDR_W   = 8;
  localparam int TICK_W  = 3;
  localparam int ID_W    = 4;
  localparam int CODE_W  = 4;
  // header plus the widest payload
  localparam int FRAME_W = HDR_W + DATA_W;
  // bit counter holds up to FRAME_W
  localparam int CNT_W   = 6;
  // half period reaches 2 * 8 cycles
  localparam int HALF_W  = TICK_W + 2;

  // payload length carried in header bits 6:5
  typedef enum logic [1:0] {
    LEN_NONE = 2'b00,
    LEN_8    = 2'b01,
    LEN_16   = 2'b10,
    LEN_32   = 2'b11
  } xcom_len_e;

  // address view reads the low nibble as a board id
  typedef struct packed {
    logic              kind_hi;
    xcom_len_e         len;
    logic              kind_lo;
    logic [ID_W-1:0]   board_id;
  } xcom_hdr_addr_t;

  // control view reads the low nibble as a control code
  typedef struct packed {
    logic              kind_hi;
    xcom_len_e         len;
    logic              kind_lo;
    logic [CODE_W-1:0] code;
  } xcom_hdr_ctrl_t;

  typedef union packed {
    xcom_hdr_addr_t addr;
    xcom_hdr_ctrl_t ctrl;
  } xcom_hdr_u;

  // processor command or received frame
  typedef struct packed {
    xcom_hdr_u         hdr;
    logic [DATA_W-1:0] data;
  } xcom_cmd_t;

  // command kind sits split over bits 7 and 4
  function automatic logic [1:0] hdr_kind(input xcom_hdr_u hdr);
    return {hdr.ctrl.kind_hi, hdr.ctrl.kind_lo};
  endfunction

  // payload bits that follow the header
  function automatic logic [CNT_W-1:0] data_bits(input xcom_len_e len);
    case (len)
      LEN_8:   return CNT_W'(8);
      LEN_16:  return CNT_W'(16);
      LEN_32:  return CNT_W'(32);
      default: return '0;
    endcase
  endfunction

  // total serial bits of one frame
  function automatic logic [CNT_W-1:0] frame_bits(input xcom_len_e len);
    return CNT_W'(HDR_W) + data_bits(len);
  endfunction

  // half period of the serial clock is 2 * (tick + 1) cycles
  function automatic logic [HALF_W-1:0] half_period(input logic [TICK_W-1:0] tick);
    return (HALF_W'(tick) + 1'b1) << 1;
  endfunction

endpackage

`default_nettype wire

// File: xcom_rx.sv
// serial receiver: input synchronizers, clock edge detect and frame deserializer
`timescale 1ns/1ns
`default_nettype none

module xcom_rx
  import xcom_link_pkg::*;
(
  input  wire logic   i_ps_clk,
  input  wire logic   i_ps_rstn,
  input  wire logic   i_xcom_clk,
  input  wire logic   i_xcom_data,
  output logic        o_frame_valid,
  output xcom_cmd_t   o_frame
);

  logic [1:0]        clk_sync;
  logic [1:0]        data_sync;
  logic              clk_prev;
  logic              clk_rise;
  logic              rx_bit;
  logic [CNT_W-1:0]  bit_cnt;
  logic              in_hdr;
  logic              frame_last;
  xcom_hdr_u         hdr_sr;
  xcom_hdr_u         hdr_next;
  xcom_hdr_u         hdr_cur;
  logic [DATA_W-1:0] data_sr;
  logic [DATA_W-1:0] data_next;

  //////////////////////////////////////////////////
  // two-flop synchronizers and edge detect
  //////////////////////////////////////////////////
  always_ff @(posedge i_ps_clk) begin
    if (!i_ps_rstn) begin
      clk_sync  <= '0;
      data_sync <= '0;
      clk_prev  <= 1'b0;
    end else begin
      clk_sync  <= {clk_sync[0], i_xcom_clk};
      data_sync <= {data_sync[0], i_xcom_data};
      clk_prev  <= clk_sync[1];
    end
  end

  assign clk_rise = clk_sync[1] && !clk_prev;
  assign rx_bit   = data_sync[1];

  //////////////////////////////////////////////////
  // deserializer
  //////////////////////////////////////////////////
  assign in_hdr   = (bit_cnt < CNT_W'(HDR_W));
  assign hdr_next = {hdr_sr[HDR_W-2:0], rx_bit};
  // length is known once the 8th header bit is in
  assign hdr_cur  = in_hdr ? hdr_next : hdr_sr;
  // payload register starts from zero, giving zero extension
  assign data_next = in_hdr ? '0 : {data_sr[DATA_W-2:0], rx_bit};
  assign frame_last = ((bit_cnt + 1'b1) == frame_bits(hdr_cur.addr.len));

  always_ff @(posedge i_ps_clk) begin
    if (!i_ps_rstn) begin
      bit_cnt       <= '0;
      o_frame_valid <= 1'b0;
    end else begin
      o_frame_valid <= 1'b0;
      if (clk_rise) begin
        if (frame_last) begin
          bit_cnt       <= '0;
          o_frame_valid <= 1'b1;
        end else begin
          bit_cnt <= bit_cnt + 1'b1;
        end
      end
    end
  end

  // shift registers and frame capture
  always_ff @(posedge i_ps_clk) begin
    if (clk_rise) begin
      if (in_hdr) begin
        hdr_sr <= hdr_next;
      end
      data_sr <= data_next;
      if (frame_last) begin
        o_frame.hdr  <= hdr_cur;
        o_frame.data <= data_next;
      end
    end
  end

endmodule

`default_nettype wire

// File: xcom_test_input.txt
// columns: header, data word, tick, expected serial bit count (all hex)
// set id commands expect 0 bits, the rest 8 header bits plus 0, 8, 16 or 32 data bits
95 00000000 0 00
20 a5a5a5c3 0 10
40 12345678 1 18
60 deadbeef 2 28
70 0badf00d 0 28
50 ffff8001 3 18
30 000000ff 7 10
81 00000000 1 08
82 ffffffff 0 08
83 00000000 2 08
84 00000000 0 08
85 00000000 1 08
a3 000000c4 0 10
9a 00000000 0 00
00 12345678 4 08

// File: xcom_top.sv
// link top: command intake, transmitter, receiver and executor
`timescale 1ns/1ns
`default_nettype none

module xcom_top
  import xcom_link_pkg::*;
  import xcom_ctrl_pkg::*;
(
  input  wire logic              i_ps_clk,
  input  wire logic              i_ps_rstn,
  input  wire logic              i_core_en,
  input  wire xcom_cmd_t         i_core_cmd,
  input  wire logic [TICK_W-1:0] i_cfg_tick,
  input  wire logic              i_sync,
  input  wire logic              i_xcom_clk,
  input  wire logic              i_xcom_data,
  output logic                   o_core_ready,
  output logic                   o_xcom_clk,
  output logic                   o_xcom_data,
  output logic [ID_W-1:0]        o_xcom_id,
  output xcom_ctrl_t             o_ctrl
);

  //////////////////////////////////////////////////
  // internal links
  //////////////////////////////////////////////////
  // command intake to transmitter
  logic      launch;
  xcom_cmd_t launch_cmd;
  logic      tx_busy;
  // receiver to executor
  logic      frame_valid;
  xcom_cmd_t frame;

  xcom_cmd xcom_cmd_i (
    .i_ps_clk     (i_ps_clk),
    .i_ps_rstn    (i_ps_rstn),
    .i_core_en    (i_core_en),
    .i_core_cmd   (i_core_cmd),
    .i_tx_busy    (tx_busy),
    .o_core_ready (o_core_ready),
    .o_launch     (launch),
    .o_launch_cmd (launch_cmd),
    .o_xcom_id    (o_xcom_id)
  );

  xcom_tx xcom_tx_i (
    .i_ps_clk     (i_ps_clk),
    .i_ps_rstn    (i_ps_rstn),
    .i_launch     (launch),
    .i_launch_cmd (launch_cmd),
    .i_cfg_tick   (i_cfg_tick),
    .o_busy       (tx_busy),
    .o_xcom_clk   (o_xcom_clk),
    .o_xcom_data  (o_xcom_data)
  );

  xcom_rx xcom_rx_i (
    .i_ps_clk      (i_ps_clk),
    .i_ps_rstn     (i_ps_rstn),
    .i_xcom_clk    (i_xcom_clk),
    .i_xcom_data   (i_xcom_data),
    .o_frame_valid (frame_valid),
    .o_frame       (frame)
  );

  xcom_exec xcom_exec_i (
    .i_ps_clk      (i_ps_clk),
    .i_ps_rstn     (i_ps_rstn),
    .i_frame_valid (frame_valid),
    .i_frame       (frame),
    .i_sync        (i_sync),
    .o_ctrl        (o_ctrl)
  );

endmodule

`default_nettype wire

// File: xcom_tx.sv
// serial transmitter: half-period divider and frame shifter for the outgoing pair
`timescale 1ns/1ns
`default_nettype none

module xcom_tx
  import xcom_link_pkg::*;
(
  input  wire logic              i_ps_clk,
  input  wire logic              i_ps_rstn,
  input  wire logic              i_launch,
  input  wire xcom_cmd_t         i_launch_cmd,
  input  wire logic [TICK_W-1:0] i_cfg_tick,
  output logic                   o_busy,
  output logic                   o_xcom_clk,
  output logic                   o_xcom_data
);

  logic [TICK_W-1:0]  tick_q;
  logic [HALF_W-1:0]  half_cnt;
  logic [CNT_W-1:0]   bits_left;
  logic [FRAME_W-1:0] shreg;
  logic [FRAME_W-1:0] frame_word;
  logic [DATA_W-1:0]  data_aligned;
  logic [CNT_W-1:0]   shift_amt;
  logic               done;
  logic               half_end;
  logic               fall_now;

  //////////////////////////////////////////////////
  // frame word at launch
  //////////////////////////////////////////////////
  // move the low n payload bits up under the header, msb first
  assign shift_amt    = CNT_W'(DATA_W) - data_bits(i_launch_cmd.hdr.addr.len);
  assign data_aligned = i_launch_cmd.data << shift_amt;
  assign frame_word   = {i_launch_cmd.hdr, data_aligned};

  assign half_end = o_busy && !done && (half_cnt == '0);
  // clock is high and its half period ran out
  assign fall_now = half_end && o_xcom_clk;

  //////////////////////////////////////////////////
  // divider and bit counter
  //////////////////////////////////////////////////
  always_ff @(posedge i_ps_clk) begin
    if (!i_ps_rstn) begin
      o_busy      <= 1'b0;
      done        <= 1'b0;
      o_xcom_clk  <= 1'b0;
      o_xcom_data <= 1'b0;
      half_cnt    <= '0;
      bits_left   <= '0;
    end else if (done) begin
      // one idle cycle after the last falling edge
      o_busy <= 1'b0;
      done   <= 1'b0;
    end else if (i_launch) begin
      o_busy      <= 1'b1;
      // first bit goes out with the launch
      o_xcom_data <= frame_word[FRAME_W-1];
      half_cnt    <= half_period(i_cfg_tick) - 1'b1;
      bits_left   <= frame_bits(i_launch_cmd.hdr.addr.len);
    end else if (o_busy) begin
      if (!half_end) begin
        half_cnt <= half_cnt - 1'b1;
      end else begin
        half_cnt <= half_period(tick_q) - 1'b1;
        if (!o_xcom_clk) begin
          o_xcom_clk <= 1'b1;
        end else begin
          o_xcom_clk <= 1'b0;
          bits_left  <= bits_left - 1'b1;
          if (bits_left == CNT_W'(1)) begin
            // frame over, line back to idle low
            done        <= 1'b1;
            o_xcom_data <= 1'b0;
          end else begin
            o_xcom_data <= shreg[FRAME_W-1];
          end
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // tick latch and shift register
  //////////////////////////////////////////////////
  always_ff @(posedge i_ps_clk) begin
    if (i_launch && !o_busy) begin
      tick_q <= i_cfg_tick;
      shreg  <= frame_word << 1;
    end else if (fall_now) begin
      // next bit presented on each falling edge
      shreg <= shreg << 1;
    end
  end

endmodule

`default_nettype wire
